//--- design/cache_pkg.sv
package cache_pkg;

   ////////////////////
   // widths
   ////////////////////
   localparam int ADDR_W     = 12;  // word address, control select bit not included
   localparam int DATA_W     = 32;
   localparam int NBYTES     = DATA_W / 8;
   localparam int INDEX_W    = 4;   // 16 lines
   localparam int WORD_W     = 2;   // 4 words per line
   localparam int TAG_W      = ADDR_W - INDEX_W - WORD_W;
   localparam int CTRL_REG_W = 2;

   // one address word, two decodings
   typedef union packed {
      struct packed {
         logic [TAG_W-1:0]   tag;
         logic [INDEX_W-1:0] index;
         logic [WORD_W-1:0]  word;
      } cache;                                 // cache path view
      struct packed {
         logic [ADDR_W-CTRL_REG_W-1:0] upper;  // ignored by the control block
         logic [CTRL_REG_W-1:0]        reg_num;
      } ctrl;                                  // control path view
   } cache_addr_u;

   // control register numbers, 3 reads as zero
   localparam logic [CTRL_REG_W-1:0] CTRL_HITS   = 2'd0;
   localparam logic [CTRL_REG_W-1:0] CTRL_MISSES = 2'd1;
   localparam logic [CTRL_REG_W-1:0] CTRL_WRITES = 2'd2;

   // byte-strobe merge of new over old
   function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_w,
                                                     input logic [DATA_W-1:0] new_w,
                                                     input logic [NBYTES-1:0] strb);
      logic [DATA_W-1:0] res;
      res = old_w;
      for (int b = 0; b < NBYTES; b++)
      begin
         if (strb[b])
            res[8*b +: 8] = new_w[8*b +: 8];
      end
      return res;
   endfunction

endpackage

//--- design/cache_front_end.sv
module cache_front_end
   import cache_pkg::*;
(
   input  logic              clk,
   input  logic              reset,
   // processor side
   input  logic [ADDR_W:0]   addr,         // msb selects control space
   input  logic [DATA_W-1:0] wdata,
   input  logic [NBYTES-1:0] wstrb,
   input  logic              valid,
   output logic              ready,
   output logic [DATA_W-1:0] rdata,
   // cache data path
   output logic              data_valid,
   output cache_addr_u       data_addr,
   output logic [DATA_W-1:0] data_wdata,
   output logic [NBYTES-1:0] data_wstrb,
   input  logic [DATA_W-1:0] data_rdata,
   input  logic              data_ready,
   // control block
   output logic              ctrl_valid,
   output cache_addr_u       ctrl_addr,
   input  logic [DATA_W-1:0] ctrl_rdata,
   input  logic              ctrl_ready
);

   logic              valid_int;   // request aimed at the cache
   logic              valid_reg;   // stored request in progress
   logic              wr_done;     // a write finished last cycle
   logic              raw_hold;
   cache_addr_u       addr_reg;
   logic [DATA_W-1:0] wdata_reg;
   logic [NBYTES-1:0] wstrb_reg;

   ////////////////////
   // steering
   ////////////////////
   assign valid_int  = valid & ~addr[ADDR_W];
   assign ctrl_valid = valid & addr[ADDR_W];
   assign ctrl_addr  = addr[ADDR_W-1:0];

   assign ready = data_ready | ctrl_ready;   // only one side answers at a time
   assign rdata = ctrl_ready ? ctrl_rdata : data_rdata;

   ////////////////////
   // stored request
   ////////////////////
   always_ff @(posedge clk)
   begin
      if (valid_int)
      begin
         addr_reg  <= addr[ADDR_W-1:0];
         wdata_reg <= wdata;
         wstrb_reg <= wstrb;
      end
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         valid_reg <= 1'b0;
         wr_done   <= 1'b0;
      end
      else
      begin
         wr_done <= data_ready & (|data_wstrb);
         if (data_ready)
            valid_reg <= 1'b0;   // answered, no repeat
         else if (valid_int)
            valid_reg <= 1'b1;
      end
   end

   // read right behind a write waits one cycle
   assign raw_hold = wr_done & ~(|wstrb);

   ////////////////////
   // data mux
   ////////////////////
   always_comb
   begin
      if (valid & ~raw_hold)
      begin
         data_addr  = addr[ADDR_W-1:0];   // live request
         data_wdata = wdata;
         data_wstrb = wstrb;
         data_valid = valid_int;
      end
      else
      begin
         data_addr  = addr_reg;           // stored request, valid already dropped
         data_wdata = wdata_reg;
         data_wstrb = wstrb_reg;
         data_valid = valid_reg;
      end
   end

   a_ready_needs_valid : assert property (@(posedge clk) disable iff (reset)
      ready |-> valid)
      else $error("ready without valid");

endmodule

//--- design/cache_line_store.sv
module cache_line_store
   import cache_pkg::*;
(
   input  logic              clk,
   input  logic              reset,
   input  cache_addr_u       lookup_addr,
   // byte-strobe write, hit only
   input  logic              wr_en,
   input  logic [NBYTES-1:0] wr_strb,
   input  logic [DATA_W-1:0] wr_data,
   // refill from memory
   input  logic              fill_en,
   input  logic [WORD_W-1:0] fill_word,
   input  logic [DATA_W-1:0] fill_data,
   input  logic              tag_set,
   output logic              hit,
   output logic [DATA_W-1:0] rd_data
);

   localparam int LINES = 2 ** INDEX_W;
   localparam int WORDS = 2 ** (INDEX_W + WORD_W);

   logic [TAG_W-1:0]   tags [LINES];
   logic [LINES-1:0]   line_valid;
   logic [DATA_W-1:0]  data [WORDS];

   logic [INDEX_W-1:0]        idx;
   logic [INDEX_W+WORD_W-1:0] rd_ptr;
   logic [INDEX_W+WORD_W-1:0] fill_ptr;

   ////////////////////
   // lookup
   ////////////////////
   assign idx      = lookup_addr.cache.index;
   assign rd_ptr   = {idx, lookup_addr.cache.word};
   assign fill_ptr = {idx, fill_word};   // refill walks the words of the same line

   assign hit     = line_valid[idx] & (tags[idx] == lookup_addr.cache.tag);
   assign rd_data = data[rd_ptr];

   // valid bits, cleared by reset
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         line_valid <= '0;
      else if (tag_set)
         line_valid[idx] <= 1'b1;   // line complete
   end

   always_ff @(posedge clk)
   begin
      if (tag_set)
         tags[idx] <= lookup_addr.cache.tag;
   end

   ////////////////////
   // data array
   ////////////////////
   always_ff @(posedge clk)
   begin
      if (fill_en)
         data[fill_ptr] <= fill_data;
      else if (wr_en)
         data[rd_ptr] <= merge_bytes(data[rd_ptr], wr_data, wr_strb);
   end

   // refill and hit write never overlap
   a_no_fill_and_write : assert property (@(posedge clk) disable iff (reset)
      !(fill_en && wr_en))
      else $error("fill and write in same cycle");

endmodule

//--- design/cache_miss_fsm.sv
module cache_miss_fsm
   import cache_pkg::*;
(
   input  logic              clk,
   input  logic              reset,
   // from the front end
   input  logic              data_valid,
   input  cache_addr_u       data_addr,
   input  logic [DATA_W-1:0] data_wdata,
   input  logic [NBYTES-1:0] data_wstrb,
   output logic              data_ready,
   output logic [DATA_W-1:0] data_rdata,
   // memory, four-phase
   output logic              mem_req,
   output logic              mem_we,
   output logic [ADDR_W-1:0] mem_addr,
   output logic [DATA_W-1:0] mem_wdata,
   input  logic [DATA_W-1:0] mem_rdata,
   input  logic              mem_ack,
   // line store
   output cache_addr_u       lookup_addr,
   output logic              wr_en,
   output logic [NBYTES-1:0] wr_strb,
   output logic [DATA_W-1:0] wr_data,
   output logic              fill_en,
   output logic [WORD_W-1:0] fill_word,
   output logic [DATA_W-1:0] fill_data,
   output logic              tag_set,
   input  logic              hit,
   input  logic [DATA_W-1:0] rd_data,
   // word counter
   output logic              cnt_clear,
   output logic              cnt_step,
   input  logic [WORD_W-1:0] cnt_word,
   input  logic              cnt_last,
   // event pulses
   output logic              ev_hit,
   output logic              ev_miss,
   output logic              ev_write
);

   localparam logic [2:0] IDLE      = 3'd0;
   localparam logic [2:0] LOOKUP    = 3'd1;
   localparam logic [2:0] FILL_REQ  = 3'd2;
   localparam logic [2:0] FILL_DROP = 3'd3;
   localparam logic [2:0] WT_REQ    = 3'd4;
   localparam logic [2:0] WT_DROP   = 3'd5;
   localparam logic [2:0] DONE      = 3'd6;

   logic [2:0]        state, nxt;
   logic              rmw;         // partial write miss, fetch the old word first
   cache_addr_u       req_addr;
   logic [DATA_W-1:0] req_wdata;
   logic [NBYTES-1:0] req_wstrb;
   logic [DATA_W-1:0] wt_data;     // merged word for write-through
   logic              is_wr, full_wr;
   logic [ADDR_W-1:0] fill_addr;

   assign is_wr     = |req_wstrb;
   assign full_wr   = &req_wstrb;
   assign fill_addr = {req_addr.cache.tag, req_addr.cache.index, cnt_word};

   assign lookup_addr = req_addr;
   assign wr_strb     = req_wstrb;
   assign wr_data     = req_wdata;
   assign fill_word   = cnt_word;
   assign fill_data   = mem_rdata;
   assign mem_wdata   = wt_data;
   assign data_rdata  = rd_data;   // refilled line is a hit in DONE

   ////////////////////
   // next state
   ////////////////////
   always_comb
   begin
      nxt        = state;
      data_ready = 1'b0;
      mem_req    = 1'b0;
      mem_we     = 1'b0;
      mem_addr   = req_addr;
      wr_en      = 1'b0;
      fill_en    = 1'b0;
      tag_set    = 1'b0;
      cnt_clear  = 1'b0;
      cnt_step   = 1'b0;
      ev_hit     = 1'b0;
      ev_miss    = 1'b0;
      ev_write   = 1'b0;
      case (state)
         IDLE:
            if (data_valid)
               nxt = LOOKUP;
         LOOKUP:
            if (is_wr)
            begin
               ev_write = 1'b1;
               wr_en    = hit;                  // no allocate on miss
               nxt      = (hit | full_wr) ? WT_REQ : FILL_REQ;
            end
            else if (hit)
            begin
               ev_hit     = 1'b1;
               data_ready = 1'b1;               // one cycle hit
               nxt        = IDLE;
            end
            else
            begin
               ev_miss   = 1'b1;
               cnt_clear = 1'b1;
               nxt       = FILL_REQ;
            end
         FILL_REQ:
         begin
            mem_req  = 1'b1;
            mem_addr = rmw ? req_addr : fill_addr;
            if (mem_ack)
            begin
               fill_en = ~rmw;                  // rdata valid while ack high
               nxt     = FILL_DROP;
            end
         end
         FILL_DROP:
         begin
            mem_addr = rmw ? req_addr : fill_addr;
            if (~mem_ack)
            begin
               if (rmw)
                  nxt = WT_REQ;
               else if (cnt_last)
               begin
                  tag_set = 1'b1;               // line complete
                  nxt     = DONE;
               end
               else
               begin
                  cnt_step = 1'b1;
                  nxt      = FILL_REQ;
               end
            end
         end
         WT_REQ:
         begin
            mem_req = 1'b1;
            mem_we  = 1'b1;
            if (mem_ack)
               nxt = WT_DROP;
         end
         WT_DROP:
         begin
            mem_we = 1'b1;
            if (~mem_ack)
               nxt = DONE;
         end
         DONE:
         begin
            data_ready = 1'b1;
            nxt        = IDLE;
         end
         default:
            nxt = IDLE;
      endcase
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         state <= IDLE;
         rmw   <= 1'b0;
      end
      else
      begin
         state <= nxt;
         if (state == LOOKUP)
            rmw <= is_wr & ~hit & ~full_wr;
      end
   end

   ////////////////////
   // request and write word
   ////////////////////
   always_ff @(posedge clk)
   begin
      if (state == IDLE && data_valid)
      begin
         req_addr  <= data_addr;
         req_wdata <= data_wdata;
         req_wstrb <= data_wstrb;
      end
      if (state == LOOKUP)
         wt_data <= merge_bytes(rd_data, req_wdata, req_wstrb);
      else if (state == FILL_REQ && rmw && mem_ack)
         wt_data <= merge_bytes(mem_rdata, req_wdata, req_wstrb);
   end

   a_req_after_ack_low : assert property (@(posedge clk) disable iff (reset)
      $rose(mem_req) |-> !mem_ack)
      else $error("mem_req rose while mem_ack high");

   a_addr_stable : assert property (@(posedge clk) disable iff (reset)
      mem_req && $past(mem_req) |-> mem_addr == $past(mem_addr))
      else $error("mem_addr changed during req");

endmodule

//--- design/cache_word_counter.sv
module cache_word_counter
   import cache_pkg::*;
(
   input  logic              clk,
   input  logic              reset,
   input  logic              cnt_clear,   // start of a refill
   input  logic              cnt_step,    // one handshake done
   output logic [WORD_W-1:0] cnt_word,
   output logic              cnt_last
);

   ////////////////////
   // refill offset
   ////////////////////
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         cnt_word <= '0;
      else if (cnt_clear)
         cnt_word <= '0;
      else if (cnt_step)
         cnt_word <= cnt_word + 1'b1;
   end

   assign cnt_last = &cnt_word;   // last word of the line

   // no wrap into the next refill
   a_no_step_past_last : assert property (@(posedge clk) disable iff (reset)
      cnt_step && cnt_last |-> cnt_clear)
      else $error("word counter stepped past last word");

endmodule

//--- design/cache_ctrl_regs.sv
module cache_ctrl_regs
   import cache_pkg::*;
(
   input  logic              clk,
   input  logic              reset,
   input  logic              ctrl_valid,
   input  cache_addr_u       ctrl_addr,
   input  logic              ev_hit,
   input  logic              ev_miss,
   input  logic              ev_write,
   output logic              ctrl_ready,
   output logic [DATA_W-1:0] ctrl_rdata
);

   logic [DATA_W-1:0] counts [3];
   logic [2:0]        ev;

   // event vector by register number
   always_comb
   begin
      ev              = '0;
      ev[CTRL_HITS]   = ev_hit;
      ev[CTRL_MISSES] = ev_miss;
      ev[CTRL_WRITES] = ev_write;
   end

   ////////////////////
   // saturating counters
   ////////////////////
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         for (int i = 0; i < 3; i++)
            counts[i] <= '0;
      end
      else
      begin
         for (int i = 0; i < 3; i++)
            if (ev[i] && ~&counts[i])
               counts[i] <= counts[i] + 1'b1;   // stick at all ones
      end
   end

   // answer one cycle later, single pulse
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         ctrl_ready <= 1'b0;
      else
         ctrl_ready <= ctrl_valid & ~ctrl_ready;
   end

   always_ff @(posedge clk)
   begin
      if (ctrl_valid)
         ctrl_rdata <= (ctrl_addr.ctrl.reg_num == 2'd3) ? '0
                                                        : counts[ctrl_addr.ctrl.reg_num];
   end

endmodule

//--- design/cache_top.sv
module cache_top
   import cache_pkg::*;
(
   input  logic              clk,
   input  logic              reset,
   // processor port
   input  logic              valid,
   input  logic [ADDR_W:0]   addr,
   input  logic [DATA_W-1:0] wdata,
   input  logic [NBYTES-1:0] wstrb,
   output logic              ready,
   output logic [DATA_W-1:0] rdata,
   // memory port
   output logic              mem_req,
   output logic              mem_we,
   output logic [ADDR_W-1:0] mem_addr,
   output logic [DATA_W-1:0] mem_wdata,
   input  logic [DATA_W-1:0] mem_rdata,
   input  logic              mem_ack
);

   ////////////////////
   // internal nets
   ////////////////////
   logic              data_valid, data_ready;
   cache_addr_u       data_addr;
   logic [DATA_W-1:0] data_wdata, data_rdata;
   logic [NBYTES-1:0] data_wstrb;
   logic              ctrl_valid, ctrl_ready;
   cache_addr_u       ctrl_addr;
   logic [DATA_W-1:0] ctrl_rdata;
   cache_addr_u       lookup_addr;
   logic              wr_en, fill_en, tag_set, hit;
   logic [NBYTES-1:0] wr_strb;
   logic [DATA_W-1:0] wr_data, fill_data, rd_data;
   logic [WORD_W-1:0] fill_word, cnt_word;
   logic              cnt_clear, cnt_step, cnt_last;
   logic              ev_hit, ev_miss, ev_write;

   cache_front_end u_front_end (
      .clk, .reset, .addr, .wdata, .wstrb, .valid, .ready, .rdata,
      .data_valid, .data_addr, .data_wdata, .data_wstrb, .data_rdata, .data_ready,
      .ctrl_valid, .ctrl_addr, .ctrl_rdata, .ctrl_ready
   );

   cache_miss_fsm u_miss_fsm (
      .clk, .reset,
      .data_valid, .data_addr, .data_wdata, .data_wstrb, .data_ready, .data_rdata,
      .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_rdata, .mem_ack,
      .lookup_addr, .wr_en, .wr_strb, .wr_data, .fill_en, .fill_word, .fill_data,
      .tag_set, .hit, .rd_data,
      .cnt_clear, .cnt_step, .cnt_word, .cnt_last,
      .ev_hit, .ev_miss, .ev_write
   );

   cache_word_counter u_word_counter (
      .clk, .reset, .cnt_clear, .cnt_step, .cnt_word, .cnt_last
   );

   cache_line_store u_line_store (
      .clk, .reset, .lookup_addr, .wr_en, .wr_strb, .wr_data,
      .fill_en, .fill_word, .fill_data, .tag_set, .hit, .rd_data
   );

   cache_ctrl_regs u_ctrl_regs (
      .clk, .reset, .ctrl_valid, .ctrl_addr, .ev_hit, .ev_miss, .ev_write,
      .ctrl_ready, .ctrl_rdata
   );

endmodule

//--- verification/main_mem_model.sv
module main_mem_model
   import cache_pkg::*;
#(
   parameter int MAX_DLY = 3   // longest ack delay per phase, cycles
)
(
   input  logic              clk,
   input  logic              reset,
   input  logic              mem_req,
   input  logic              mem_we,
   input  logic [ADDR_W-1:0] mem_addr,
   input  logic [DATA_W-1:0] mem_wdata,
   output logic [DATA_W-1:0] mem_rdata,
   output logic              mem_ack,
   // back door for the testbench
   input  logic [ADDR_W-1:0] peek_addr,
   output logic [DATA_W-1:0] peek_data
);
   timeunit 1ns;
   timeprecision 1ps;

   logic [DATA_W-1:0] mem [2**ADDR_W];
   int unsigned       wait_cnt;   // cycles left before ack moves

   // start contents, every address bit matters
   function automatic logic [DATA_W-1:0] fill_pattern(input int unsigned a);
      return (a * 32'h0004_0021) ^ 32'hc3a5_0000 ^ a;
   endfunction

   initial
   begin
      for (int i = 0; i < 2**ADDR_W; i++)
         mem[i] <= fill_pattern(i);
   end

   assign peek_data = mem[peek_addr];

   ////////////////////
   // four-phase responder
   ////////////////////
   always @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         mem_ack   <= 1'b0;
         mem_rdata <= '0;
         wait_cnt  <= 0;
      end
      else if (mem_req != mem_ack)   // phase open, ack must follow req
      begin
         if (wait_cnt != 0)
            wait_cnt <= wait_cnt - 1;
         else
         begin
            mem_ack  <= mem_req;
            wait_cnt <= $urandom_range(MAX_DLY, 0);   // delay of the next phase
            if (mem_req && mem_we)
               mem[mem_addr] <= mem_wdata;
            else if (mem_req)
               mem_rdata <= mem[mem_addr];           // valid while ack high
         end
      end
   end

endmodule

//--- verification/cache_tb.sv
module cache_tb
   import cache_pkg::*;
();
   timeunit 1ns;
   timeprecision 1ps;

   localparam int CLK_PERIOD = 20;
   localparam int RESET_CYC  = 16;
   localparam int SEED       = 32;
   localparam int MAX_DLY    = 3;
   localparam int MIX_REQS   = 40;
   localparam int TOTAL_REQS = 80;                        // bound over all tests
   localparam int REFILL_CYC = 4 * 2 * (MAX_DLY + 2) + 8;   // worst read miss

   logic              clk;
   logic              reset;
   logic              valid;
   logic [ADDR_W:0]   addr;
   logic [DATA_W-1:0] wdata;
   logic [NBYTES-1:0] wstrb;
   logic              ready;
   logic [DATA_W-1:0] rdata;
   logic              mem_req, mem_we, mem_ack;
   logic [ADDR_W-1:0] mem_addr;
   logic [DATA_W-1:0] mem_wdata, mem_rdata;
   logic [ADDR_W-1:0] peek_addr;
   logic [DATA_W-1:0] peek_data;

   // expectations, held through the ready edge
   logic              chk_rdata, chk_mem, chk_lat, chk_miss;
   logic [DATA_W-1:0] exp_rdata, exp_mem;
   int                exp_lat, act_lat;

   // reference model
   logic [DATA_W-1:0] ref_mem [2**ADDR_W];
   logic [TAG_W-1:0]  ref_tag [2**INDEX_W];
   logic              ref_ok  [2**INDEX_W];
   int                cnt_hits, cnt_misses, cnt_writes;
   logic              last_wr;   // previous request was a cache write

   string             test_name;
   int                err_cnt, req_cnt, test_cnt, test_err0, test_req0;

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   cache_top UUT (
      .clk, .reset, .valid, .addr, .wdata, .wstrb, .ready, .rdata,
      .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_rdata, .mem_ack
   );

   main_mem_model #(.MAX_DLY(MAX_DLY)) u_mem (
      .clk, .reset, .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_rdata, .mem_ack,
      .peek_addr, .peek_data
   );

   ////////////////////
   // checks
   ////////////////////
   a_reset_quiet : assert property (@(posedge clk) reset |=> !ready && !mem_req && !mem_we)
      else begin
         $display("%s: ready or memory request active after reset", test_name);
         err_cnt++;
      end

   a_read_data : assert property (@(posedge clk) disable iff (reset)
      ready && chk_rdata |-> rdata == exp_rdata)
      else begin
         $display("ERR %s: rdata expected %h actual %h", test_name,
                  $sampled(exp_rdata), $sampled(rdata));
         err_cnt++;
      end

   a_mem_word : assert property (@(posedge clk) disable iff (reset)
      ready && chk_mem |-> peek_data == exp_mem)
      else begin
         $display("ERR %s: memory word expected %h actual %h", test_name,
                  $sampled(exp_mem), $sampled(peek_data));
         err_cnt++;
      end

   a_hit_latency : assert property (@(posedge clk) disable iff (reset)
      ready && chk_lat |-> act_lat == exp_lat)
      else begin
         $display("ERR %s: latency expected %0d actual %0d", test_name,
                  $sampled(exp_lat), $sampled(act_lat));
         err_cnt++;
      end

   // a refill is four handshakes of at least four cycles
   a_miss_latency : assert property (@(posedge clk) disable iff (reset)
      ready && chk_miss |-> act_lat > 8)
      else begin
         $display("%s: read predicted as miss answered after only %0d cycles",
                  test_name, $sampled(act_lat));
         err_cnt++;
      end

   a_req_rise : assert property (@(posedge clk) disable iff (reset)
      $rose(mem_req) |-> !mem_ack)
      else begin
         $display("%s: mem_req rose while mem_ack was still high", test_name);
         err_cnt++;
      end

   a_addr_hold : assert property (@(posedge clk) disable iff (reset)
      mem_req && $past(mem_req) |-> mem_addr == $past(mem_addr))
      else begin
         $display("%s: mem_addr changed while mem_req was high", test_name);
         err_cnt++;
      end

   ////////////////////
   // helpers
   ////////////////////
   function automatic logic [DATA_W-1:0] fill_pattern(input int unsigned a);
      return (a * 32'h0004_0021) ^ 32'hc3a5_0000 ^ a;   // same start image as memory
   endfunction

   function automatic logic [DATA_W-1:0] strobe_merge(input logic [DATA_W-1:0] old_w,
                                                      input logic [DATA_W-1:0] new_w,
                                                      input logic [NBYTES-1:0] strb);
      logic [DATA_W-1:0] mask;
      mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
      return (old_w & ~mask) | (new_w & mask);
   endfunction

   // two tags only, so lines get reused and evicted
   function automatic logic [ADDR_W-1:0] rand_addr();
      logic [31:0] r;
      r = $urandom_range(1, 0) * 64 + $urandom_range(63, 0);
      return r[ADDR_W-1:0];
   endfunction

   function automatic logic [NBYTES-1:0] rand_strb();
      logic [31:0] r;
      r = $urandom_range(15, 1);   // never zero, that would be a read
      return r[NBYTES-1:0];
   endfunction

   // one request, model first, then hold valid until ready
   task automatic issue(input logic ctrl, input logic [ADDR_W-1:0] a,
                        input logic [DATA_W-1:0] wd, input logic [NBYTES-1:0] st);
      logic [TAG_W-1:0]   tag;
      logic [INDEX_W-1:0] idx;
      logic               hit;
      int                 cyc;
      tag       = a[ADDR_W-1 -: TAG_W];
      idx       = a[WORD_W +: INDEX_W];
      hit       = ref_ok[idx] && (ref_tag[idx] == tag);
      chk_rdata = 1'b0;
      chk_mem   = 1'b0;
      chk_lat   = 1'b0;
      chk_miss  = 1'b0;
      if (ctrl)
      begin
         chk_rdata = 1'b1;
         chk_lat   = 1'b1;
         exp_lat   = 1;   // control space never held
         case (a[CTRL_REG_W-1:0])
            CTRL_HITS:   exp_rdata = cnt_hits;
            CTRL_MISSES: exp_rdata = cnt_misses;
            CTRL_WRITES: exp_rdata = cnt_writes;
            default:     exp_rdata = '0;
         endcase
      end
      else if (|st)
      begin
         cnt_writes++;   // no allocate, tags untouched
         ref_mem[a] = strobe_merge(ref_mem[a], wd, st);
         chk_mem    = 1'b1;
         peek_addr  = a;
         exp_mem    = ref_mem[a];
      end
      else
      begin
         chk_rdata = 1'b1;
         exp_rdata = ref_mem[a];   // cache mirrors memory, write-through
         if (hit)
         begin
            cnt_hits++;
            chk_lat = 1'b1;
            exp_lat = last_wr ? 2 : 1;   // extra cycle behind a write
         end
         else
         begin
            cnt_misses++;
            chk_miss     = 1'b1;
            ref_ok[idx]  = 1'b1;
            ref_tag[idx] = tag;
         end
      end
      last_wr = !ctrl && (|st);
      valid   = 1'b1;
      addr    = {ctrl, a};
      wdata   = wd;
      wstrb   = st;
      cyc     = 0;
      do
      begin
         @(negedge clk);
         cyc++;
      end
      while (!ready);
      act_lat = cyc - 1;
      @(posedge clk);
      #1;
      valid     = 1'b0;
      chk_rdata = 1'b0;
      chk_mem   = 1'b0;
      chk_lat   = 1'b0;
      chk_miss  = 1'b0;
      req_cnt++;
   endtask

   task automatic idle(input int n);
      repeat (n) @(posedge clk);
      #1;
      last_wr = 1'b0;   // hold only covers the very next cycle
   endtask

   task automatic read_counters();
      for (int r = 0; r < 4; r++)
         issue(1'b1, ADDR_W'(r), '0, '0);
   endtask

   task automatic begin_test(input string name);
      test_name = name;
      test_err0 = err_cnt;
      test_req0 = req_cnt;
   endtask

   task automatic end_test();
      test_cnt++;
      $display("test %s: %0d requests, %0d errors", test_name,
               req_cnt - test_req0, err_cnt - test_err0);
   endtask

   ////////////////////
   // stimulus
   ////////////////////
   initial
   begin
      logic [ADDR_W-1:0] a;
      logic [ADDR_W-1:0] b;
      int                op;
      void'($urandom(SEED));
      valid     = 1'b0;
      addr      = '0;
      wdata     = '0;
      wstrb     = '0;
      peek_addr = '0;
      chk_rdata = 1'b0;
      chk_mem   = 1'b0;
      chk_lat   = 1'b0;
      chk_miss  = 1'b0;
      exp_rdata = '0;
      exp_mem   = '0;
      exp_lat   = 0;
      act_lat   = 0;
      last_wr   = 1'b0;
      cnt_hits  = 0;
      cnt_misses = 0;
      cnt_writes = 0;
      err_cnt   = 0;
      req_cnt   = 0;
      test_cnt  = 0;
      test_name = "reset";
      for (int i = 0; i < 2**ADDR_W; i++)
         ref_mem[i] = fill_pattern(i);
      for (int i = 0; i < 2**INDEX_W; i++)
      begin
         ref_ok[i]  = 1'b0;
         ref_tag[i] = '0;
      end
      reset = 1'b1;
      repeat (RESET_CYC) @(posedge clk);
      #1;
      reset = 1'b0;

      begin_test("reset");
      read_counters();                          // all zero, reg 3 too
      end_test();

      begin_test("miss_hit");
      a = rand_addr();
      issue(1'b0, a, '0, '0);                   // refill
      issue(1'b0, a, '0, '0);                   // one cycle hit
      issue(1'b0, a ^ 12'd1, '0, '0);           // other word, same line
      issue(1'b0, a ^ 12'd64, '0, '0);          // same index, other tag
      issue(1'b0, a, '0, '0);                   // evicted, miss again
      end_test();

      begin_test("write_through");
      a = rand_addr();
      b = a ^ 12'd64;
      issue(1'b0, a, '0, '0);
      idle(2);
      issue(1'b0, a, $urandom, rand_strb());    // write hit
      idle(1);
      issue(1'b0, a, '0, '0);
      issue(1'b0, b, $urandom, rand_strb());    // write miss, no allocate
      idle(1);
      issue(1'b0, b, '0, '0);                   // so this misses
      issue(1'b0, b ^ 12'd1, $urandom, 4'hf);   // full word write hit
      idle(1);
      issue(1'b0, b ^ 12'd1, '0, '0);
      end_test();

      begin_test("read_after_write");
      a = rand_addr();
      b = a ^ 12'd64;
      issue(1'b0, a, '0, '0);
      issue(1'b0, a, $urandom, rand_strb());
      issue(1'b0, a, '0, '0);                   // held a cycle, new data
      issue(1'b0, b, $urandom, rand_strb());    // line absent
      issue(1'b0, b, '0, '0);
      end_test();

      begin_test("protocol");
      for (int n = 0; n < MIX_REQS; n++)
      begin
         a  = rand_addr();
         op = $urandom_range(3, 0);
         if (op == 0)
            issue(1'b0, a, $urandom, rand_strb());
         else
            issue(1'b0, a, '0, '0);
         if ($urandom_range(1, 0) == 1)
            idle(1);
      end
      end_test();

      begin_test("counters");
      read_counters();
      end_test();

      $display("summary: %0d tests, %0d requests, %0d errors", test_cnt, req_cnt, err_cnt);
      if (err_cnt == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

   // watchdog, every request at worst refill time
   initial
   begin
      #((RESET_CYC + TOTAL_REQS * REFILL_CYC) * CLK_PERIOD);
      $display("watchdog expired in %s, a request was never answered", test_name);
      $display("Test failed");
      $finish;
   end

endmodule

//--- cache_sys.f
design/cache_pkg.sv
design/cache_front_end.sv
design/cache_line_store.sv
design/cache_miss_fsm.sv
design/cache_word_counter.sv
design/cache_ctrl_regs.sv
design/cache_top.sv
verification/main_mem_model.sv
verification/cache_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the cache testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module cache_tb -f cache_sys.f

./obj_dir/Vcache_tb | tee sim.log

if grep -q "Test failed" sim.log; then
   echo "simulation FAILED, see sim.log"
   exit 1
fi

echo "simulation passed"
exit 0
